// ==== common/battleship_config.svh ====
// --------------------
// Battleship build parameters.
// Board size, fleet limit, turn length and enemy seed.
// --------------------
`ifndef BATTLESHIP_CONFIG_SVH
`define BATTLESHIP_CONFIG_SVH

// Cells per board side.
`define BOARD_SIZE 5

// Largest fleet the player may choose.
`define MAX_SHIPS 5

// Ticks per player turn.
`define TURN_TICKS 12
`define ENEMY_SEED 16'hACE1

`endif

// ==== common/battleshipPkg.sv ====
// --------------------
// Battleship shared types.
// Coordinates, counts, cell codes and FSM states.
// --------------------
package battleshipPkg;

	typedef logic [2:0] coord_t;
	typedef logic [2:0] count_t;

	// Two bits per board cell.
	typedef enum logic [1:0] {
		cellEmpty = 2'd0,
		cellShip  = 2'd1,
		cellMiss  = 2'd2,
		cellHit   = 2'd3
	} cell_t;

	typedef enum logic [1:0] {
		gamePlaying = 2'd0,
		gameVictory = 2'd2,
		gameDefeat  = 2'd3
	} gameState_t;

	// Game controller FSM.
	typedef enum logic [2:0] {
		selectFleet, placeShips, playerTurn, checkWin,
		enemyTurn, checkLoss, gameOver
	} ctrlState_t;

endpackage

// ==== verilog/cursorControl.sv ====
// --------------------
// Cursor control.
// One-hot moves step a saturating cursor.
// --------------------
`include "battleship_config.svh"

module cursorControl (
	input  logic clk,
	input  logic rst,
	input  logic [3:0] mov,
	output battleshipPkg::coord_t curX,
	output battleshipPkg::coord_t curY
);

	localparam battleshipPkg::coord_t MAX_POS = 3'(`BOARD_SIZE - 1);

	// Non one-hot values fall to default.
	always_ff @(posedge clk) begin
		if (rst) begin
			curX <= '0;
			curY <= '0;
		end else begin
			case (mov)
				4'b1000: if (curX != '0) curX <= curX - 3'd1;
				4'b0100: if (curY != '0) curY <= curY - 3'd1;
				4'b0010: if (curY != MAX_POS) curY <= curY + 3'd1;
				4'b0001: if (curX != MAX_POS) curX <= curX + 3'd1;
				default: begin
				end
			endcase
		end
	end

endmodule

// ==== fleet/fleetBoard.sv ====
// --------------------
// Fleet board.
// Stores one side's cells, resolves placements
// and shots, and counts ships still afloat.
// --------------------
`include "battleship_config.svh"

module fleetBoard (
	input  logic clk,
	input  logic rst,
	input  logic clear,
	input  logic place,
	input  logic fire,
	input  battleshipPkg::coord_t cellX,
	input  battleshipPkg::coord_t cellY,
	output logic accepted,
	output logic wasHit,
	output logic [2*`BOARD_SIZE*`BOARD_SIZE-1:0] board,
	output battleshipPkg::count_t shipsLeft
);

	localparam int NUM_CELLS = `BOARD_SIZE * `BOARD_SIZE;

	battleshipPkg::cell_t cells [NUM_CELLS];
	int idx;

	// Row major cell index.
	always_comb begin
		idx = int'(cellY) * `BOARD_SIZE + int'(cellX);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_CELLS; i++) begin
				cells[i] <= battleshipPkg::cellEmpty;
			end
			accepted <= 1'b0;
			wasHit   <= 1'b0;
		end else begin
			accepted <= 1'b0;
			wasHit   <= 1'b0;
			if (clear) begin
				for (int i = 0; i < NUM_CELLS; i++) begin
					cells[i] <= battleshipPkg::cellEmpty;
				end
			end else if (place) begin
				if (cells[idx] == battleshipPkg::cellEmpty) begin
					cells[idx] <= battleshipPkg::cellShip;
					accepted   <= 1'b1;
				end
			end else if (fire) begin
				// Cells already fired at are left alone.
				if (cells[idx] == battleshipPkg::cellEmpty) begin
					cells[idx] <= battleshipPkg::cellMiss;
					accepted   <= 1'b1;
				end else if (cells[idx] == battleshipPkg::cellShip) begin
					cells[idx] <= battleshipPkg::cellHit;
					accepted   <= 1'b1;
					wasHit     <= 1'b1;
				end
			end
		end
	end

	// --------------------
	// Flat board and ship count.
	always_comb begin
		shipsLeft = '0;
		for (int i = 0; i < NUM_CELLS; i++) begin
			board[2*i +: 2] = cells[i];
			if (cells[i] == battleshipPkg::cellShip) begin
				shipsLeft = shipsLeft + 3'd1;
			end
		end
	end

endmodule

// ==== fleet/enemyAgent.sv ====
// --------------------
// Enemy agent.
// LFSR picks candidate cells for enemy
// placement and enemy shots.
// --------------------
`include "battleship_config.svh"

module enemyAgent (
	input  logic clk,
	input  logic rst,
	input  logic enable,
	output battleshipPkg::coord_t candX,
	output battleshipPkg::coord_t candY
);

	// x^16 + x^14 + x^13 + x^11 + 1, maximal length.
	localparam logic [15:0] TAPS = 16'hB400;

	logic [15:0] lfsr;
	battleshipPkg::coord_t rawX;
	battleshipPkg::coord_t rawY;

	// Folds 5..7 back onto the board.
	function automatic battleshipPkg::coord_t wrapToBoard(input battleshipPkg::coord_t v);
		battleshipPkg::coord_t r;
		if (v >= 3'(`BOARD_SIZE)) begin
			r = v - 3'(`BOARD_SIZE);
		end else begin
			r = v;
		end
		return r;
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			lfsr <= `ENEMY_SEED;
		end else if (enable) begin
			lfsr <= {1'b0, lfsr[15:1]} ^ (lfsr[0] ? TAPS : 16'h0000);
		end
	end

	// Column from the low bits, row above it.
	always_comb begin
		rawX  = lfsr[2:0];
		rawY  = lfsr[5:3];
		candX = wrapToBoard(rawX);
		candY = wrapToBoard(rawY);
	end

endmodule

// ==== verilog/gameControl.sv ====
// --------------------
// Game control FSM.
// Runs fleet setup, alternating turns and the
// turn timer, and routes actions to both boards.
// --------------------
`include "battleship_config.svh"

module gameControl (
	input  logic clk,
	input  logic rst,
	input  logic confirm,
	input  logic tick,
	input  battleshipPkg::count_t fleetSize,
	input  battleshipPkg::coord_t curX,
	input  battleshipPkg::coord_t curY,
	input  battleshipPkg::coord_t candX,
	input  battleshipPkg::coord_t candY,
	input  logic playerAccepted,
	input  logic enemyAccepted,
	input  battleshipPkg::count_t playerShipsLeft,
	input  battleshipPkg::count_t enemyShipsLeft,
	output logic playerPlace,
	output logic playerFire,
	output logic enemyPlace,
	output logic enemyFire,
	output logic clearBoards,
	output battleshipPkg::coord_t playerCellX,
	output battleshipPkg::coord_t playerCellY,
	output battleshipPkg::coord_t enemyCellX,
	output battleshipPkg::coord_t enemyCellY,
	output logic agentEnable,
	output logic [3:0] turnTime,
	output battleshipPkg::gameState_t gameState
);

	battleshipPkg::ctrlState_t state, nextState;
	battleshipPkg::count_t fleet, playerPlaced, enemyPlaced;
	battleshipPkg::count_t playerCount, enemyCount;
	logic fleetValid;
	logic shotPending;

	// --------------------
	// Requests and routing.
	always_comb begin
		fleetValid  = (fleetSize != '0) && (fleetSize <= 3'(`MAX_SHIPS));
		// Placed so far, including the answer arriving now.
		playerCount = playerPlaced + {2'b00, playerAccepted};
		enemyCount  = enemyPlaced + {2'b00, enemyAccepted};
		playerPlace = (state == battleshipPkg::placeShips) && confirm && (playerCount < fleet);
		enemyPlace  = (state == battleshipPkg::placeShips) && (enemyCount < fleet);
		enemyFire   = (state == battleshipPkg::playerTurn) && confirm && !shotPending &&
			(turnTime != 4'd0);
		playerFire  = (state == battleshipPkg::enemyTurn) && !playerAccepted;
		clearBoards = (state == battleshipPkg::selectFleet);
		agentEnable = enemyPlace || (state == battleshipPkg::enemyTurn);
		playerCellX = (state == battleshipPkg::enemyTurn) ? candX : curX;
		playerCellY = (state == battleshipPkg::enemyTurn) ? candY : curY;
		enemyCellX  = (state == battleshipPkg::placeShips) ? candX : curX;
		enemyCellY  = (state == battleshipPkg::placeShips) ? candY : curY;
	end

	always_comb begin
		nextState = state;
		case (state)
			battleshipPkg::selectFleet:
				if (confirm && fleetValid) nextState = battleshipPkg::placeShips;
			battleshipPkg::placeShips:
				if (playerPlaced == fleet && enemyPlaced == fleet) begin
					nextState = battleshipPkg::playerTurn;
				end
			battleshipPkg::playerTurn:
				if (shotPending && enemyAccepted) begin
					nextState = battleshipPkg::checkWin;
				end else if (turnTime == 4'd0) begin
					nextState = battleshipPkg::enemyTurn;
				end
			battleshipPkg::checkWin:
				nextState = (enemyShipsLeft == '0) ? battleshipPkg::gameOver :
					battleshipPkg::enemyTurn;
			battleshipPkg::enemyTurn:
				if (playerAccepted) nextState = battleshipPkg::checkLoss;
			battleshipPkg::checkLoss:
				nextState = (playerShipsLeft == '0) ? battleshipPkg::gameOver :
					battleshipPkg::playerTurn;
			battleshipPkg::gameOver:
				nextState = battleshipPkg::gameOver;
			default:
				nextState = battleshipPkg::selectFleet;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state        <= battleshipPkg::selectFleet;
			fleet        <= '0;
			playerPlaced <= '0;
			enemyPlaced  <= '0;
			shotPending  <= 1'b0;
			turnTime     <= 4'd0;
			gameState    <= battleshipPkg::gamePlaying;
		end else begin
			state       <= nextState;
			shotPending <= enemyFire;
			if (state == battleshipPkg::selectFleet && confirm && fleetValid) fleet <= fleetSize;
			if (state == battleshipPkg::placeShips) begin
				playerPlaced <= playerCount;
				enemyPlaced  <= enemyCount;
			end
			// Load on turn entry, count down on tick.
			if (nextState == battleshipPkg::playerTurn && state != battleshipPkg::playerTurn) begin
				turnTime <= 4'(`TURN_TICKS);
			end else if (state == battleshipPkg::playerTurn && tick && turnTime != 4'd0) begin
				turnTime <= turnTime - 4'd1;
			end
			if (state == battleshipPkg::checkWin && enemyShipsLeft == '0) begin
				gameState <= battleshipPkg::gameVictory;
			end
			if (state == battleshipPkg::checkLoss && playerShipsLeft == '0) begin
				gameState <= battleshipPkg::gameDefeat;
			end
		end
	end

endmodule

// ==== verilog/segDisplay.sv ====
// --------------------
// Two-digit seven-segment encoder.
// Active low gfedcba, tens digit on top.
// --------------------
module segDisplay (
	input  logic [3:0] value,
	output logic [13:0] seg
);

	logic [3:0] tens;
	logic [3:0] ones;

	function automatic logic [6:0] encodeDigit(input logic [3:0] d);
		logic [6:0] s;
		case (d)
			4'd0: s = 7'b1000000;
			4'd1: s = 7'b1111001;
			4'd2: s = 7'b0100100;
			4'd3: s = 7'b0110000;
			4'd4: s = 7'b0011001;
			4'd5: s = 7'b0010010;
			4'd6: s = 7'b0000010;
			4'd7: s = 7'b1111000;
			4'd8: s = 7'b0000000;
			4'd9: s = 7'b0010000;
			default: s = 7'b1111111;
		endcase
		return s;
	endfunction

	always_comb begin
		tens = (value >= 4'd10) ? 4'd1 : 4'd0;
		ones = (value >= 4'd10) ? value - 4'd10 : value;
		seg  = {encodeDigit(tens), encodeDigit(ones)};
	end

endmodule

// ==== verilog/battleship.sv ====
// --------------------
// Battleship top level.
// Cursor input, game control, two boards,
// enemy agent and three displays.
// --------------------
`include "battleship_config.svh"

module battleship (
	input  logic clk,
	input  logic rst,
	input  logic confirm,
	input  logic tick,
	input  battleshipPkg::count_t fleetSize,
	input  logic [3:0] mov,
	output battleshipPkg::coord_t curX,
	output battleshipPkg::coord_t curY,
	output logic [2*`BOARD_SIZE*`BOARD_SIZE-1:0] playerBoard,
	output logic [2*`BOARD_SIZE*`BOARD_SIZE-1:0] enemyView,
	output battleshipPkg::gameState_t gameState,
	output logic [13:0] dispTime,
	output logic [13:0] dispPlayerShips,
	output logic [13:0] dispEnemyShips
);

	localparam int NUM_CELLS = `BOARD_SIZE * `BOARD_SIZE;

	logic [2*NUM_CELLS-1:0] enemyBoard;
	logic playerPlace, playerFire, enemyPlace, enemyFire, clearBoards;
	logic playerAccepted, enemyAccepted, agentEnable;
	battleshipPkg::coord_t playerCellX, playerCellY, enemyCellX, enemyCellY;
	battleshipPkg::coord_t candX, candY;
	battleshipPkg::count_t playerShipsLeft, enemyShipsLeft;
	logic [3:0] turnTime;

	cursorControl iCursor (.clk(clk), .rst(rst), .mov(mov), .curX(curX), .curY(curY));

	gameControl iControl (
		.clk(clk), .rst(rst), .confirm(confirm), .tick(tick), .fleetSize(fleetSize),
		.curX(curX), .curY(curY), .candX(candX), .candY(candY),
		.playerAccepted(playerAccepted), .enemyAccepted(enemyAccepted),
		.playerShipsLeft(playerShipsLeft), .enemyShipsLeft(enemyShipsLeft),
		.playerPlace(playerPlace), .playerFire(playerFire), .enemyPlace(enemyPlace),
		.enemyFire(enemyFire), .clearBoards(clearBoards),
		.playerCellX(playerCellX), .playerCellY(playerCellY),
		.enemyCellX(enemyCellX), .enemyCellY(enemyCellY),
		.agentEnable(agentEnable), .turnTime(turnTime), .gameState(gameState)
	);

	fleetBoard iPlayerBoard (
		.clk(clk), .rst(rst), .clear(clearBoards), .place(playerPlace), .fire(playerFire),
		.cellX(playerCellX), .cellY(playerCellY), .accepted(playerAccepted), .wasHit(),
		.board(playerBoard), .shipsLeft(playerShipsLeft)
	);

	fleetBoard iEnemyBoard (
		.clk(clk), .rst(rst), .clear(clearBoards), .place(enemyPlace), .fire(enemyFire),
		.cellX(enemyCellX), .cellY(enemyCellY), .accepted(enemyAccepted), .wasHit(),
		.board(enemyBoard), .shipsLeft(enemyShipsLeft)
	);

	enemyAgent iAgent (.clk(clk), .rst(rst), .enable(agentEnable), .candX(candX), .candY(candY));

	segDisplay iTimeDisp (.value(turnTime), .seg(dispTime));
	segDisplay iPlayerDisp (.value({1'b0, playerShipsLeft}), .seg(dispPlayerShips));
	segDisplay iEnemyDisp (.value({1'b0, enemyShipsLeft}), .seg(dispEnemyShips));

	// Hide enemy ships that are still afloat.
	always_comb begin
		for (int i = 0; i < NUM_CELLS; i++) begin
			enemyView[2*i +: 2] = (enemyBoard[2*i +: 2] == battleshipPkg::cellShip) ?
				2'(battleshipPkg::cellEmpty) : enemyBoard[2*i +: 2];
		end
	end

endmodule

// ==== verification/battleshipTb.sv ====
// --------------------
// Battleship testbench.
// Random cursor moves, fleet setup and a full game,
// checked against a model of the player's side.
// --------------------
`include "battleship_config.svh"

module battleshipTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_CELLS = `BOARD_SIZE * `BOARD_SIZE;
	localparam int WAIT_LIMIT = 2000;
	localparam int TICKS = `TURN_TICKS;

	logic clk;
	logic rst;
	logic confirm;
	logic tick;
	battleshipPkg::count_t fleetSize;
	logic [3:0] mov;
	battleshipPkg::coord_t curX;
	battleshipPkg::coord_t curY;
	logic [2*NUM_CELLS-1:0] playerBoard;
	logic [2*NUM_CELLS-1:0] enemyView;
	battleshipPkg::gameState_t gameState;
	logic [13:0] dispTime;
	logic [13:0] dispPlayerShips;
	logic [13:0] dispEnemyShips;

	// Model state.
	logic [31:0] rngState;
	int modelX;
	int modelY;
	bit ownShip [NUM_CELLS];
	bit enemyShotAt [NUM_CELLS];
	bit playerShotAt [NUM_CELLS];
	int playerLeft;
	int enemyLeft;
	int fleet;
	int errs [6];
	int checks;
	int curTest;
	bit aborted;
	bit over;

	battleship i_battleship (
		.clk(clk), .rst(rst), .confirm(confirm), .tick(tick), .fleetSize(fleetSize),
		.mov(mov), .curX(curX), .curY(curY), .playerBoard(playerBoard),
		.enemyView(enemyView), .gameState(gameState), .dispTime(dispTime),
		.dispPlayerShips(dispPlayerShips), .dispEnemyShips(dispEnemyShips)
	);

	always #2 clk = ~clk;

	// Galois LFSR, one step per bit taken.
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] r;
		logic lsb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lsb = rngState[0];
			rngState = (rngState >> 1) ^ (lsb ? 32'h8020_0003 : 32'h0);
			r = {r[30:0], lsb};
		end
		return r;
	endfunction

	function automatic logic [1:0] cellAt(input logic [2*NUM_CELLS-1:0] b, input int i);
		return b[2*i +: 2];
	endfunction

	// Lit segments as gfedcba, then inverted for active low.
	function automatic logic [6:0] digitSeg(input int d);
		logic [6:0] lit;
		case (d)
			0: lit = 7'h3F;
			1: lit = 7'h06;
			2: lit = 7'h5B;
			3: lit = 7'h4F;
			4: lit = 7'h66;
			5: lit = 7'h6D;
			6: lit = 7'h7D;
			7: lit = 7'h07;
			8: lit = 7'h7F;
			9: lit = 7'h6F;
			default: lit = 7'h00;
		endcase
		return ~lit;
	endfunction

	function automatic logic [13:0] segOf(input int v);
		return {digitSeg(v / 10), digitSeg(v % 10)};
	endfunction

	// Random start, then the first cell whose flag matches.
	function automatic int pickCell(input bit used [NUM_CELLS], input bit want);
		int start;
		int i;
		start = int'(randBits(5)) % NUM_CELLS;
		for (int k = 0; k < NUM_CELLS; k++) begin
			i = (start + k) % NUM_CELLS;
			if (used[i] == want) return i;
		end
		return -1;
	endfunction

	function automatic string testLabel(input int t);
		case (t)
			0: return "cursor";
			1: return "fleet setup";
			2: return "player shots";
			3: return "enemy shots";
			4: return "timer";
			default: return "end of game";
		endcase
	endfunction

	task automatic checkEq(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			errs[curTest]++;
			$display("ERR t=%0t %s: got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic reportFailure(input string what);
		errs[curTest]++;
		$display("Failure at time %0t: %s", $time, what);
	endtask

	task automatic reportTimeout(input string what);
		errs[curTest]++;
		aborted = 1'b1;
		$display("Timeout at time %0t while waiting for %s", $time, what);
	endtask

	task automatic finishTest(input int t);
		$display("Test %s: %0d errors%s", testLabel(t), errs[t], aborted ? " (run stopped)" : "");
	endtask

	task automatic applyMove(input logic [3:0] m);
		mov = m;
		@(negedge clk);
		case (m)
			4'b1000: modelX = (modelX > 0) ? modelX - 1 : 0;
			4'b0100: modelY = (modelY > 0) ? modelY - 1 : 0;
			4'b0010: modelY = (modelY < `BOARD_SIZE - 1) ? modelY + 1 : modelY;
			4'b0001: modelX = (modelX < `BOARD_SIZE - 1) ? modelX + 1 : modelX;
			default: ;
		endcase
	endtask

	task automatic moveTo(input int x, input int y);
		while (modelX < x) begin
			applyMove(4'b0001);
		end
		while (modelX > x) begin
			applyMove(4'b1000);
		end
		while (modelY < y) begin
			applyMove(4'b0010);
		end
		while (modelY > y) begin
			applyMove(4'b0100);
		end
		mov = '0;
		checkEq("curX", curX, x);
		checkEq("curY", curY, y);
	endtask

	task automatic pressConfirm();
		confirm = 1'b1;
		@(negedge clk);
		confirm = 1'b0;
	endtask

	task automatic awaitPlayerTurn();
		int n;
		n = 0;
		while (dispTime != segOf(TICKS) && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (dispTime != segOf(TICKS)) reportTimeout("the turn timer to load");
	endtask

	task automatic awaitState(input battleshipPkg::gameState_t s);
		int n;
		n = 0;
		while (gameState != s && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (gameState != s) reportTimeout("the game to end");
	endtask

	task automatic playerShot();
		logic [2*NUM_CELLS-1:0] snap;
		int idx;
		int n;
		int diffs;
		idx = pickCell(playerShotAt, 1'b1);
		// A second shot at an old cell must be ignored.
		if (idx >= 0 && randBits(1) == 32'd1) begin
			moveTo(idx % `BOARD_SIZE, idx / `BOARD_SIZE);
			snap = enemyView;
			pressConfirm();
			@(negedge clk);
			checkEq("enemyView", enemyView, snap);
		end
		idx = pickCell(playerShotAt, 1'b0);
		moveTo(idx % `BOARD_SIZE, idx / `BOARD_SIZE);
		snap = enemyView;
		pressConfirm();
		n = 0;
		while (enemyView == snap && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (enemyView == snap) begin
			reportTimeout("the player's shot to land");
		end else begin
			diffs = 0;
			for (int i = 0; i < NUM_CELLS; i++) begin
				if (cellAt(enemyView, i) != cellAt(snap, i)) diffs++;
			end
			checkEq("changed enemyView cells", diffs, 1);
			if (cellAt(enemyView, idx) == battleshipPkg::cellHit) begin
				enemyLeft--;
			end else begin
				checkEq("enemyView cell", cellAt(enemyView, idx), battleshipPkg::cellMiss);
			end
			playerShotAt[idx] = 1'b1;
			checkEq("dispEnemyShips", dispEnemyShips, segOf(enemyLeft));
		end
	endtask

	task automatic enemyShot();
		logic [2*NUM_CELLS-1:0] snap;
		logic [1:0] expCell;
		int n;
		int diffs;
		int hitIdx;
		snap = playerBoard;
		n = 0;
		while (playerBoard == snap && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (playerBoard == snap) begin
			reportTimeout("the enemy's shot");
		end else begin
			diffs = 0;
			hitIdx = -1;
			for (int i = 0; i < NUM_CELLS; i++) begin
				if (cellAt(playerBoard, i) != cellAt(snap, i)) begin
					diffs++;
					hitIdx = i;
				end
			end
			checkEq("changed playerBoard cells", diffs, 1);
			assert (!enemyShotAt[hitIdx]) else begin
				reportFailure("enemy fired at a cell it had already hit");
			end
			expCell = ownShip[hitIdx] ? 2'(battleshipPkg::cellHit) : 2'(battleshipPkg::cellMiss);
			checkEq("playerBoard cell", cellAt(playerBoard, hitIdx), expCell);
			if (ownShip[hitIdx] && !enemyShotAt[hitIdx]) playerLeft--;
			enemyShotAt[hitIdx] = 1'b1;
			checkEq("dispPlayerShips", dispPlayerShips, segOf(playerLeft));
		end
	endtask

	task automatic afterEnemyShot();
		if (playerLeft == 0) begin
			awaitState(battleshipPkg::gameDefeat);
			over = 1'b1;
		end else begin
			// Check loss takes one cycle, then the turn reloads.
			repeat (2) @(negedge clk);
			awaitPlayerTurn();
			checkEq("gameState", gameState, battleshipPkg::gamePlaying);
		end
	endtask

	initial begin
		logic [2*NUM_CELLS-1:0] expBoard;
		logic [2*NUM_CELLS-1:0] snapP;
		logic [2*NUM_CELLS-1:0] snapE;
		battleshipPkg::gameState_t endState;
		int len;
		int idx;
		int n;
		int rounds;
		int total;
		clk = 1'b0;
		rst = 1'b1;
		confirm = 1'b0;
		tick = 1'b0;
		fleetSize = '0;
		mov = '0;
		rngState = 32'h219c_8edb;
		modelX = 0;
		modelY = 0;
		checks = 0;
		aborted = 1'b0;
		over = 1'b0;
		foreach (errs[i]) errs[i] = 0;
		foreach (ownShip[i]) begin
			ownShip[i] = 1'b0;
			enemyShotAt[i] = 1'b0;
			playerShotAt[i] = 1'b0;
		end
		repeat (5) @(negedge clk);
		rst = 1'b0;

		// --------------------
		// Cursor.
		curTest = 0;
		for (int s = 0; s < 10; s++) begin
			len = 6 + int'(randBits(3));
			for (int m = 0; m < len; m++) begin
				applyMove(4'(randBits(4)));
			end
			mov = '0;
			checkEq("curX", curX, modelX);
			checkEq("curY", curY, modelY);
		end
		finishTest(0);

		// --------------------
		// Fleet setup.
		curTest = 1;
		checkEq("gameState", gameState, battleshipPkg::gamePlaying);
		checkEq("playerBoard", playerBoard, 0);
		for (int k = 0; k < 3; k++) begin
			fleetSize = (k == 0) ? 3'd0 : 3'(k + 5);
			pressConfirm();
			repeat (4) @(negedge clk);
			checkEq("dispEnemyShips", dispEnemyShips, segOf(0));
			checkEq("dispTime", dispTime, segOf(0));
		end
		fleet = 1 + int'(randBits(3)) % `MAX_SHIPS;
		fleetSize = 3'(fleet);
		pressConfirm();
		fleetSize = 3'(randBits(3));
		for (int k = 0; k < fleet; k++) begin
			idx = pickCell(ownShip, 1'b0);
			moveTo(idx % `BOARD_SIZE, idx / `BOARD_SIZE);
			pressConfirm();
			n = 0;
			while (cellAt(playerBoard, idx) != battleshipPkg::cellShip && n < WAIT_LIMIT) begin
				@(negedge clk);
				n++;
			end
			if (cellAt(playerBoard, idx) != battleshipPkg::cellShip) begin
				reportTimeout("a ship placement");
				break;
			end
			ownShip[idx] = 1'b1;
		end
		if (!aborted) awaitPlayerTurn();
		expBoard = '0;
		for (int i = 0; i < NUM_CELLS; i++) begin
			if (ownShip[i]) expBoard[2*i +: 2] = battleshipPkg::cellShip;
		end
		checkEq("playerBoard", playerBoard, expBoard);
		checkEq("dispPlayerShips", dispPlayerShips, segOf(fleet));
		checkEq("dispEnemyShips", dispEnemyShips, segOf(fleet));
		playerLeft = fleet;
		enemyLeft = fleet;
		finishTest(1);

		// --------------------
		// Timer runs out, then the enemy fires.
		curTest = 4;
		if (!aborted) begin
			for (int t = TICKS - 1; t >= 0; t--) begin
				tick = 1'b1;
				@(negedge clk);
				tick = 1'b0;
				// The enemy shot follows at once when the timer reaches 0.
				if (t > 0) begin
					repeat (int'(randBits(2))) @(negedge clk);
				end
				checkEq("dispTime", dispTime, segOf(t));
			end
			enemyShot();
			if (!aborted) afterEnemyShot();
		end
		finishTest(4);

		// --------------------
		// Alternating turns until the game ends.
		rounds = 0;
		while (!over && !aborted && rounds < 2 * NUM_CELLS) begin
			rounds++;
			curTest = 2;
			playerShot();
			if (!aborted && enemyLeft == 0) begin
				awaitState(battleshipPkg::gameVictory);
				over = 1'b1;
			end else if (!aborted) begin
				curTest = 3;
				enemyShot();
				if (!aborted) afterEnemyShot();
			end
		end
		if (!over && !aborted) reportFailure("the game did not end");
		finishTest(2);
		finishTest(3);

		// Boards are frozen once the game is over.
		curTest = 5;
		if (over && !aborted) begin
			snapP = playerBoard;
			snapE = enemyView;
			endState = gameState;
			for (int c = 0; c < 40; c++) begin
				mov = 4'(randBits(4));
				confirm = 1'(randBits(1));
				tick = 1'(randBits(1));
				fleetSize = 3'(randBits(3));
				@(negedge clk);
			end
			mov = '0;
			confirm = 1'b0;
			tick = 1'b0;
			checkEq("playerBoard", playerBoard, snapP);
			checkEq("enemyView", enemyView, snapE);
			checkEq("gameState", gameState, endState);
		end
		finishTest(5);

		total = 0;
		foreach (errs[i]) total += errs[i];
		$display("Tests: 6, checks: %0d, errors: %0d", checks, total);
		if (total == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+common
common/battleshipPkg.sv
verilog/cursorControl.sv
fleet/fleetBoard.sv
fleet/enemyAgent.sv
verilog/gameControl.sv
verilog/segDisplay.sv
verilog/battleship.sv
verification/battleshipTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the battleship testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	-f src.f --top-module battleshipTb --Mdir obj_dir -o simBattleship
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simBattleship > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Finished with no errors$" "$LOG"; then
	exit 0
fi
exit 1
